//--- Bender.yml
package:
  name: crypto_core

export_include_dirs:
  - source

sources:
  - source/crypto_pkg.sv
  - source/sync_fifo.sv
  - source/receive_buffer.sv
  - source/key_expander.sv
  - source/cipher_unit.sv
  - source/mcu_controller.sv
  - source/crypto_core.sv
  - target: test
    files:
      - test/crypto_core_sva.sv
      - test/crypto_core_checker.sv
      - test/crypto_core_tb.sv

//--- crypto_core.f
+incdir+source
source/crypto_pkg.sv
source/sync_fifo.sv
source/receive_buffer.sv
source/key_expander.sv
source/cipher_unit.sv
source/mcu_controller.sv
source/crypto_core.sv
test/crypto_core_sva.sv
test/crypto_core_checker.sv
test/crypto_core_tb.sv

//--- source/cipher_unit.sv
// Single byte encrypt/decrypt stage with mode and pending result registers.
module cipher_unit
	import crypto_pkg::*;
(
	input  logic  clk,
	input  logic  n_reset,
	input  logic  is_encrypt,
	input  logic  is_decrypt,
	input  byte_t rx_head,
	input  logic  rcv_deq,
	input  key_t  round_key,
	input  logic  tx_full,
	input  logic  trans_enq,
	output byte_t result,
	output logic  accepted,
	output logic  data_done
);

	cipher_mode_t mode;
	logic pending;
	byte_t k_lo;
	byte_t k_hi;
	byte_t enc_byte;
	byte_t dec_byte;
	byte_t mixed;
	byte_t shifted;

	assign k_lo = round_key[7:0];
	assign k_hi = round_key[15:8];

	always_comb begin
		mixed = rx_head ^ k_lo;
		enc_byte = {mixed[6:0], mixed[7]} + k_hi;
		shifted = rx_head - k_hi;
		dec_byte = {shifted[0], shifted[7:1]} ^ k_lo;
	end

	assign accepted = !pending;
	assign data_done = pending && !tx_full;  // Result waits while the queue is full.

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			mode <= MODE_ENCRYPT;
			pending <= 1'b0;
		end else begin
			if (is_encrypt)
				mode <= MODE_ENCRYPT;
			else if (is_decrypt)
				mode <= MODE_DECRYPT;
			if (rcv_deq)
				pending <= 1'b1;
			else if (trans_enq)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rcv_deq)
			result <= (mode == MODE_DECRYPT) ? dec_byte : enc_byte;
	end

endmodule

//--- source/crypto_core.sv
// Top level of the byte stream cipher peripheral.
`include "crypto_defines.svh"

module crypto_core
	import crypto_pkg::*;
(
	input  logic       clk,
	input  logic       n_reset,
	input  byte_t      rx_data,
	input  logic       rx_strobe,
	input  logic       rx_framing_error,
	input  key_t       key_data,
	input  logic       key_strobe,
	input  logic       encrypt_pulse,
	input  logic       decrypt_pulse,
	input  logic       tx_pop,
	output byte_t      tx_data,
	output logic       tx_empty,
	output logic [4:0] status_bits
);

	byte_t rx_head;
	logic rx_empty;
	logic rx_full;
	logic framing_error;
	key_t key_head;
	logic key_empty;
	key_t round_key;
	byte_t result;
	logic tx_full;
	logic accepted;
	logic data_done;
	logic is_encrypt;
	logic is_decrypt;
	logic read_fifo;  // Observed by the bound assertions.
	logic rcv_deq;
	logic fix_error;
	logic trans_enq;
	logic read_fifo_key_gen;
	logic key_step;

	receive_buffer u_rx_buf (
		.clk(clk), .n_reset(n_reset),
		.rx_data(rx_data), .rx_strobe(rx_strobe), .rx_framing_error(rx_framing_error),
		.fix_error(fix_error), .rcv_deq(rcv_deq),
		.head(rx_head), .empty(rx_empty), .full(rx_full), .framing_error(framing_error)
	);

	sync_fifo #(.payload_t(key_t), .depth(`CRYPTO_FIFO_DEPTH)) u_key_fifo (
		.clk(clk), .n_reset(n_reset),
		.push(key_strobe), .push_data(key_data), .pop(read_fifo_key_gen),
		.head(key_head), .empty(key_empty), .full()
	);

	sync_fifo #(.payload_t(byte_t), .depth(`CRYPTO_FIFO_DEPTH)) u_tx_fifo (
		.clk(clk), .n_reset(n_reset),
		.push(trans_enq), .push_data(result), .pop(tx_pop),
		.head(tx_data), .empty(tx_empty), .full(tx_full)
	);

	key_expander u_key_exp (
		.clk(clk), .n_reset(n_reset),
		.key_head(key_head), .load(read_fifo_key_gen), .key_step(key_step),
		.round_key(round_key)
	);

	cipher_unit u_cipher (
		.clk(clk), .n_reset(n_reset),
		.is_encrypt(is_encrypt), .is_decrypt(is_decrypt),
		.rx_head(rx_head), .rcv_deq(rcv_deq), .round_key(round_key),
		.tx_full(tx_full), .trans_enq(trans_enq),
		.result(result), .accepted(accepted), .data_done(data_done)
	);

	mcu_controller u_ctrl (
		.clk(clk), .n_reset(n_reset),
		.key_empty(key_empty),
		.is_encryption_pulse(encrypt_pulse), .is_decryption_pulse(decrypt_pulse),
		.empty_rx(rx_empty), .full_rx(rx_full), .empty_tx(tx_empty),
		.framing_error(framing_error), .accepted(accepted), .data_done(data_done),
		.is_encrypt(is_encrypt), .is_decrypt(is_decrypt), .read_fifo(read_fifo),
		.rcv_deq(rcv_deq), .fix_error(fix_error), .trans_enq(trans_enq),
		.read_fifo_key_gen(read_fifo_key_gen), .key_step(key_step),
		.status_bits(status_bits)
	);

endmodule

//--- source/crypto_defines.svh
// Crypto peripheral sizing and key schedule constants.
`ifndef CRYPTO_DEFINES_SVH
`define CRYPTO_DEFINES_SVH

// Entries in every FIFO of the core.
`define CRYPTO_FIFO_DEPTH 8

// Left rotation applied to the key in each round.
`define KEY_ROTATE 5

// Constant mixed into the key in each round.
`define KEY_MIX 16'hA5C3

`endif

//--- source/crypto_pkg.sv
// Shared payload, mode and controller state types for the crypto core.
package crypto_pkg;

	typedef logic [7:0] byte_t;  // Data byte.
	typedef logic [15:0] key_t;  // Cipher key.

	typedef enum logic {
		MODE_ENCRYPT = 1'b0,
		MODE_DECRYPT = 1'b1
	} cipher_mode_t;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_GET_KEY,
		ST_KEY_R1,
		ST_KEY_R2,
		ST_KEY_R3,
		ST_ENCRYPT,
		ST_DECRYPT,
		ST_GET_DATA,
		ST_DID_READ,
		ST_FIX_RX,
		ST_ENQ_TX
	} ctrl_state_t;

endpackage

//--- source/key_expander.sv
// Round key register with a rotate and mix expansion step.
`include "crypto_defines.svh"

module key_expander
	import crypto_pkg::*;
(
	input  logic clk,
	input  logic n_reset,
	input  key_t key_head,
	input  logic load,
	input  logic key_step,
	output key_t round_key
);

	key_t next_round;

	// One round of the toy key schedule.
	always_comb begin
		next_round = (round_key << `KEY_ROTATE) | (round_key >> (16 - `KEY_ROTATE));
		next_round = next_round ^ `KEY_MIX;
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			round_key <= '0;
		else if (load)
			round_key <= key_head;  // Fresh key from the queue.
		else if (key_step)
			round_key <= next_round;
	end

endmodule

//--- source/mcu_controller.sv
// Sequencing FSM for key loading, mode changes and byte transfer, with status word.
module mcu_controller
	import crypto_pkg::*;
(
	input  logic       clk,
	input  logic       n_reset,
	input  logic       key_empty,
	input  logic       is_encryption_pulse,
	input  logic       is_decryption_pulse,
	input  logic       empty_rx,
	input  logic       full_rx,
	input  logic       empty_tx,
	input  logic       framing_error,
	input  logic       accepted,
	input  logic       data_done,
	output logic       is_encrypt,
	output logic       is_decrypt,
	output logic       read_fifo,
	output logic       rcv_deq,
	output logic       fix_error,
	output logic       trans_enq,
	output logic       read_fifo_key_gen,
	output logic       key_step,
	output logic [4:0] status_bits
);

	ctrl_state_t state;
	ctrl_state_t nxt_state;
	logic key_ready;

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			state <= ST_IDLE;
			key_ready <= 1'b0;
		end else begin
			state <= nxt_state;
			if (state == ST_KEY_R3)
				key_ready <= 1'b1;  // Sticky until reset.
		end
	end

	// Later checks in idle override earlier ones.
	always_comb begin
		nxt_state = state;
		case (state)
			ST_IDLE: begin
				if (!key_empty)
					nxt_state = ST_GET_KEY;
				if (is_decryption_pulse)
					nxt_state = ST_DECRYPT;
				if (is_encryption_pulse)
					nxt_state = ST_ENCRYPT;
				if (framing_error)
					nxt_state = ST_FIX_RX;
				// A stalled result must reach the queue before the next read.
				if (!empty_rx && accepted)
					nxt_state = ST_GET_DATA;
				if (data_done)
					nxt_state = ST_ENQ_TX;
			end
			ST_GET_KEY:  nxt_state = ST_KEY_R1;
			ST_KEY_R1:   nxt_state = ST_KEY_R2;
			ST_KEY_R2:   nxt_state = ST_KEY_R3;
			ST_KEY_R3:   nxt_state = ST_IDLE;
			ST_GET_DATA: nxt_state = ST_DID_READ;
			ST_DID_READ: nxt_state = accepted ? ST_IDLE : ST_GET_DATA;
			default:     nxt_state = ST_IDLE;
		endcase
	end

	assign read_fifo_key_gen = (state == ST_GET_KEY);
	assign key_step = (state == ST_KEY_R1) || (state == ST_KEY_R2) || (state == ST_KEY_R3);
	assign is_encrypt = (state == ST_ENCRYPT);
	assign is_decrypt = (state == ST_DECRYPT);
	assign read_fifo = (state == ST_GET_DATA);
	assign rcv_deq = (state == ST_DID_READ) && accepted;
	assign fix_error = (state == ST_FIX_RX);
	assign trans_enq = (state == ST_ENQ_TX);

	assign status_bits = {key_ready, is_encrypt, is_decrypt, !empty_tx, full_rx};

endmodule

//--- source/receive_buffer.sv
// Receive byte queue with a sticky framing error flag.
module receive_buffer
	import crypto_pkg::*;
(
	input  logic  clk,
	input  logic  n_reset,
	input  byte_t rx_data,
	input  logic  rx_strobe,
	input  logic  rx_framing_error,
	input  logic  fix_error,
	input  logic  rcv_deq,
	output byte_t head,
	output logic  empty,
	output logic  full,
	output logic  framing_error
);

	logic rx_good;

	assign rx_good = rx_strobe && !rx_framing_error;  // Bad bytes are discarded.

	sync_fifo #(
		.payload_t(byte_t)
	) u_rx_fifo (
		.clk      (clk),
		.n_reset  (n_reset),
		.push     (rx_good),
		.push_data(rx_data),
		.pop      (rcv_deq),
		.head     (head),
		.empty    (empty),
		.full     (full)
	);

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			framing_error <= 1'b0;
		else if (rx_strobe && rx_framing_error)
			framing_error <= 1'b1;  // A new error wins over repair.
		else if (fix_error)
			framing_error <= 1'b0;
	end

endmodule

//--- source/sync_fifo.sv
// Show-ahead synchronous FIFO with a configurable payload type.
`include "crypto_defines.svh"

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = `CRYPTO_FIFO_DEPTH
) (
	input  logic     clk,
	input  logic     n_reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == cnt_w'(depth));
	assign do_push = push && !full;  // Drop writes when full.
	assign do_pop = pop && !empty;
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

//--- test/crypto_core_checker.sv
// Scoreboard for transmitted bytes, round key and status bits of the crypto core.
module crypto_core_checker
	import crypto_pkg::*;
(
	input  logic       clk,
	input  logic       n_reset,
	input  byte_t      tx_data,
	input  logic       tx_pop,
	input  logic       tx_empty,
	input  logic [4:0] status_bits,
	input  logic       encrypt_pulse,
	input  logic       decrypt_pulse,
	input  logic       exp_valid,
	input  byte_t      exp_byte,
	input  logic       key_check,
	input  key_t       exp_key,
	input  key_t       round_key,
	output int         errors,
	output int         left_over,
	output logic       saw_rx_full
);
	timeunit 1ns;
	timeprecision 1ps;

	byte_t expq [$];  // Bytes still owed by the DUT, in order.
	byte_t want;
	logic [1:0] mode_pulses;  // Encrypt and decrypt pulses of the previous cycle.

	initial begin
		errors = 0;
		left_over = 0;
		saw_rx_full = 1'b0;
		mode_pulses = 2'b00;
	end

	always @(posedge clk) begin
		if (n_reset) begin
			// Nothing owed means the transmit queue must be empty.
			if (expq.size() == 0 && {status_bits[1], tx_empty} !== 2'b01) begin
				$display("Error %0t: no byte owed, status bit 1 is %b with tx_empty %b",
					$time, status_bits[1], tx_empty);
				errors++;
			end
			if (tx_pop && status_bits[1] !== 1'b1) begin
				$display("Error %0t: status bit 1 is %b while a byte is popped",
					$time, status_bits[1]);
				errors++;
			end
			if (status_bits[3:2] !== mode_pulses) begin
				$display("Error %0t: mode status bits %b, expected %b",
					$time, status_bits[3:2], mode_pulses);
				errors++;
			end
			if (exp_valid)
				expq.push_back(exp_byte);
			if (tx_pop && !tx_empty) begin
				if (expq.size() == 0) begin
					$display("Error %0t: unexpected byte %h transmitted", $time, tx_data);
					errors++;
				end else begin
					want = expq.pop_front();
					if (tx_data !== want) begin
						$display("Error %0t: transmitted %h, expected %h", $time, tx_data, want);
						errors++;
					end
				end
			end
			if (key_check && {status_bits[4], round_key} !== {1'b1, exp_key}) begin
				$display("Error %0t: round key %h key-ready %b, expected %h with key-ready",
					$time, round_key, status_bits[4], exp_key);
				errors++;
			end
			if (status_bits[0])
				saw_rx_full = 1'b1;
			left_over = expq.size();
		end
		mode_pulses <= {encrypt_pulse, decrypt_pulse};
	end

endmodule

//--- test/crypto_core_input.txt
// Columns: opcode_argument_expected. 01 key/round key, 02 encrypt, 03 decrypt,
// 04 byte/output byte, 05 error byte, 06 wait cycles, 07 hold cycles, 00 end.
07_012c_0000
04_0080_0001
04_00c3_0087
04_0001_0002
04_007f_00fe
04_00a5_004b
04_0010_0020
04_00ff_00ff
04_003c_0078
04_0096_002d
06_003c_0000
04_0055_00aa
04_00aa_0055
04_000f_001e
04_00f0_00e1
04_0011_0022
04_0088_0011
04_0042_0084
04_00e7_00cf
06_0190_0000
01_1234_1a3a
04_0012_006a
04_0081_0091
04_00f0_00af
06_0028_0000
03_0000_0000
04_006a_0012
04_0091_0081
04_00af_00f0
06_0028_0000
02_0000_0000
04_0000_008e
04_0033_002c
05_0077_0000
04_0044_0016
06_0028_0000
00_0000_0000

//--- test/crypto_core_sva.sv
// Controller strobe and transmit queue assertions for the crypto core.
module crypto_core_sva (
	input logic       clk,
	input logic       n_reset,
	input logic       is_encrypt,
	input logic       is_decrypt,
	input logic       read_fifo,
	input logic       rcv_deq,
	input logic       fix_error,
	input logic       trans_enq,
	input logic       read_fifo_key_gen,
	input logic       key_step,
	input logic       tx_full,
	input logic [4:0] status_bits
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	strobes_exclusive: assert property (@(posedge clk) disable iff (!n_reset)
		$onehot0({is_encrypt, is_decrypt, read_fifo, rcv_deq, fix_error, trans_enq,
			read_fifo_key_gen, key_step}))
	else begin
		$error("Controller strobes overlap");
		fail_count++;
	end

	enq_not_full: assert property (@(posedge clk) disable iff (!n_reset)
		trans_enq |-> !tx_full)
	else begin
		$error("Transmit enqueue while the queue is full");
		fail_count++;
	end

	key_ready_sticky: assert property (@(posedge clk) disable iff (!n_reset)
		!$fell(status_bits[4]))
	else begin
		$error("Key-ready fell after rising");
		fail_count++;
	end

endmodule

bind crypto_core crypto_core_sva sva0 (.*);

//--- test/crypto_core_tb.sv
// Testbench for the crypto core, driven by a command file with expected results.
module crypto_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic n_reset;
	logic [7:0] rx_data;
	logic rx_strobe;
	logic rx_framing_error;
	logic [15:0] key_data;
	logic key_strobe;
	logic encrypt_pulse;
	logic decrypt_pulse;
	logic tx_pop;
	logic [7:0] tx_data;
	logic tx_empty;
	logic [4:0] status_bits;
	logic exp_valid;
	logic [7:0] exp_byte;
	logic key_check;
	logic [15:0] exp_key;
	logic saw_rx_full;
	logic [39:0] cmds [64];  // Opcode, argument and expected value.
	int errors;
	int left_over;
	int hold_until = 0;
	int cycles = 0;
	int limit = 1000000;

	crypto_core dut0 (.*);

	crypto_core_checker check0 (.*, .round_key(dut0.round_key));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Drain the transmit queue unless held.
	always @(negedge clk)
		tx_pop <= n_reset && !tx_empty && (cycles >= hold_until);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, the command file did not complete", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int n;
		int total;
		logic [7:0] op;
		logic [15:0] arg;
		logic [15:0] expv;
		void'($urandom(28));
		n_reset = 1'b0;
		{rx_strobe, rx_framing_error, key_strobe, encrypt_pulse, decrypt_pulse} = '0;
		{tx_pop, exp_valid, key_check} = '0;
		{rx_data, key_data, exp_byte, exp_key} = '0;
		$readmemh("test/crypto_core_input.txt", cmds);
		total = 0;
		for (n = 0; n < 64 && cmds[n][39:32] != 8'h00; n++)
			total += (cmds[n][39:32] >= 8'h06) ? int'(cmds[n][31:16]) : 10;
		limit = 4 * total + 200;
		repeat (3) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b1;
		@(negedge clk);
		for (n = 0; n < 64 && cmds[n][39:32] != 8'h00; n++) begin
			op = cmds[n][39:32];
			arg = cmds[n][31:16];
			expv = cmds[n][15:0];
			case (op)
				8'h01: begin
					{key_data, exp_key, key_strobe} = {arg, expv, 1'b1};
					@(negedge clk);
					key_strobe = 1'b0;
					repeat (7) @(negedge clk);  // Key pop and three rounds.
					key_check = 1'b1;
					@(negedge clk);
					key_check = 1'b0;
				end
				8'h02, 8'h03: begin
					{encrypt_pulse, decrypt_pulse} = {op == 8'h02, op == 8'h03};
					@(negedge clk);
					{encrypt_pulse, decrypt_pulse} = '0;
				end
				8'h04, 8'h05: begin
					{rx_data, rx_strobe, rx_framing_error} = {arg[7:0], 1'b1, op == 8'h05};
					{exp_valid, exp_byte} = {op == 8'h04, expv[7:0]};
					@(negedge clk);
					{rx_strobe, rx_framing_error, exp_valid} = '0;
					repeat ($urandom_range(3, 1)) @(negedge clk);
				end
				8'h06: repeat (arg) @(negedge clk);
				8'h07: hold_until = cycles + int'(arg);
				default: ;
			endcase
		end
		if (left_over != 0)
			$display("%0d expected bytes were never transmitted", left_over);
		if (!saw_rx_full)
			$display("The receive-full status bit never rose");
		$display("Checks done: %0d errors, %0d missing bytes, %0d assertion failures",
			errors, left_over, dut0.sva0.fail_count);
		if (errors == 0 && left_over == 0 && saw_rx_full && dut0.sva0.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
